// File: verilog/stepper_pkg.sv
// Shared definitions for the stepper drive controller.
// Register map, control bits, coil patterns and bus vector types.
package stepper_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus and coil vector types
    //////////////////////////////////////////////////////////////////////

    typedef logic [3:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Coil wires in the order A+, A-, B+, B- from bit 3 down to bit 0.
    typedef logic [3:0]  coil_t;

    //////////////////////////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////////////////////////

    localparam apb_addr_t CTRL_ADDR   = 4'h0;
    localparam apb_addr_t SPEED_ADDR  = 4'h4;
    localparam apb_addr_t PHASE_ADDR  = 4'h8;
    localparam apb_addr_t STATUS_ADDR = 4'hC;

    // Bit positions inside the CTRL register.
    localparam int CTRL_RUN   = 0;
    localparam int CTRL_MICRO = 1;
    localparam int CTRL_NANO  = 2;
    localparam int CTRL_ASYNC = 3;
    localparam int CTRL_OE    = 4;

    // Full-step sequence, indexed by the step position modulo 4.
    localparam coil_t COIL_PATTERN [0:3] = '{
        4'b1010,
        4'b0110,
        4'b0101,
        4'b1001
    };

endpackage

// File: verilog/stepper_regs.sv
// APB register file of the stepper drive.
// Holds control, speed and phase load, and reads back live phase and coil.
`timescale 1ns/10ps

module stepper_regs #(
    parameter int PHASE_WIDTH = 32
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  stepper_pkg::apb_addr_t paddr,
    input  stepper_pkg::apb_data_t pwdata,
    output stepper_pkg::apb_data_t prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic [PHASE_WIDTH-1:0] phase,
    input  stepper_pkg::coil_t     coil,
    output logic                   run,
    output logic                   micro_en,
    output logic                   nano_en,
    output logic                   async_en,
    output logic                   oe,
    output logic [PHASE_WIDTH-1:0] speed,
    output logic                   phase_load_valid,
    output logic [PHASE_WIDTH-1:0] phase_load_value
);

    logic                   setup_phase;
    logic                   write_access;
    stepper_pkg::apb_data_t read_mux;

    // Every access finishes in its access phase.
    assign pready       = 1'b1;
    assign setup_phase  = psel && !penable;
    assign write_access = psel && penable && pwrite;

    //////////////////////////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        read_mux = '0;
        case (paddr)
            stepper_pkg::CTRL_ADDR: begin
                read_mux[stepper_pkg::CTRL_RUN]   = run;
                read_mux[stepper_pkg::CTRL_MICRO] = micro_en;
                read_mux[stepper_pkg::CTRL_NANO]  = nano_en;
                read_mux[stepper_pkg::CTRL_ASYNC] = async_en;
                read_mux[stepper_pkg::CTRL_OE]    = oe;
            end
            stepper_pkg::SPEED_ADDR:  read_mux[PHASE_WIDTH-1:0] = speed;
            stepper_pkg::PHASE_ADDR:  read_mux[PHASE_WIDTH-1:0] = phase;
            stepper_pkg::STATUS_ADDR: read_mux[3:0] = coil;
            default:                  read_mux = '0;
        endcase
    end

    // Read data and the error flag are captured in the setup phase,
    // so both are valid throughout the access phase.
    always_ff @(posedge clk) begin
        if (reset) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else begin
            pslverr <= setup_phase && (paddr > stepper_pkg::STATUS_ADDR);
            if (setup_phase && !pwrite) begin
                prdata <= read_mux;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Write path
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            run              <= 1'b0;
            micro_en         <= 1'b0;
            nano_en          <= 1'b0;
            async_en         <= 1'b0;
            oe               <= 1'b0;
            speed            <= '0;
            phase_load_valid <= 1'b0;
        end else begin
            phase_load_valid <= 1'b0;
            if (write_access) begin
                case (paddr)
                    stepper_pkg::CTRL_ADDR: begin
                        run      <= pwdata[stepper_pkg::CTRL_RUN];
                        micro_en <= pwdata[stepper_pkg::CTRL_MICRO];
                        nano_en  <= pwdata[stepper_pkg::CTRL_NANO];
                        async_en <= pwdata[stepper_pkg::CTRL_ASYNC];
                        oe       <= pwdata[stepper_pkg::CTRL_OE];
                    end
                    stepper_pkg::SPEED_ADDR: speed <= pwdata[PHASE_WIDTH-1:0];
                    stepper_pkg::PHASE_ADDR: phase_load_valid <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // The load value only matters while the load pulse is high.
    always_ff @(posedge clk) begin
        if (write_access && (paddr == stepper_pkg::PHASE_ADDR)) begin
            phase_load_value <= pwdata[PHASE_WIDTH-1:0];
        end
    end

endmodule

// File: verilog/phase_generator.sv
// Electrical phase accumulator of the stepper drive.
// Loads a host phase or adds the signed speed once per PWM period.
`timescale 1ns/10ps

module phase_generator #(
    parameter int PHASE_WIDTH = 32
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   run,
    input  logic [PHASE_WIDTH-1:0] speed,
    input  logic                   update,
    input  logic                   phase_load_valid,
    input  logic [PHASE_WIDTH-1:0] phase_load_value,
    output logic [PHASE_WIDTH-1:0] phase
);

    typedef logic [PHASE_WIDTH-1:0] phase_t;

    phase_t phase_next;

    // Speed is two's complement, so a plain add wraps in both directions.
    always_comb begin
        phase_next = phase;
        if (phase_load_valid) begin
            phase_next = phase_load_value;
        end else if (run && update) begin
            phase_next = phase + speed;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Phase register
    //////////////////////////////////////////////////////////////////////

    // A host load wins over accumulation in the same cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= '0;
        end else begin
            phase <= phase_next;
        end
    end

endmodule

// File: verilog/microstep_pwm_control.sv
// Microstep PWM control of the stepper drive.
// Dithers the fractional phase into a time share of the next integer step.
`timescale 1ns/10ps

module microstep_pwm_control #(
    parameter int PHASE_WIDTH     = 32,
    parameter int Q_WIDTH         = 16,
    parameter int MICROSTEP_WIDTH = 12,
    parameter int OUTPUT_WIDTH    = PHASE_WIDTH - Q_WIDTH
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    microstep_en,
    input  logic                    nanostep_en,
    input  logic                    async_update_en,
    input  logic [PHASE_WIDTH-1:0]  phase,
    output logic                    update,
    output logic [OUTPUT_WIDTH-1:0] out_val
);

    localparam int NANOSTEP_WIDTH = (Q_WIDTH > MICROSTEP_WIDTH) ?
                                    (Q_WIDTH - MICROSTEP_WIDTH) : 1;

    typedef logic [PHASE_WIDTH-1:0] phase_t;

    logic [MICROSTEP_WIDTH-1:0] micro_cnt;
    logic [NANOSTEP_WIDTH-1:0]  nano_cnt;
    phase_t                     micro_scaled;
    phase_t                     nano_rev;
    phase_t                     st0_phase;
    phase_t                     st1_phase;

    //////////////////////////////////////////////////////////////////////
    // Counter scaling
    //////////////////////////////////////////////////////////////////////

    // The micro counter sweeps the top fraction bits within one period.
    // The nano counter fills the bits below it, bit reversed, so its
    // extra share is spread evenly over successive periods.
    if (Q_WIDTH > MICROSTEP_WIDTH) begin : g_scale_up
        assign micro_scaled = phase_t'(micro_cnt) << (Q_WIDTH - MICROSTEP_WIDTH);
        always_comb begin
            nano_rev = '0;
            for (int i = 0; i < NANOSTEP_WIDTH; i++) begin
                nano_rev[i] = nano_cnt[NANOSTEP_WIDTH-1-i];
            end
        end
    end else begin : g_scale_down
        assign micro_scaled = phase_t'(micro_cnt >> (MICROSTEP_WIDTH - Q_WIDTH));
        assign nano_rev     = '0;
    end

    //////////////////////////////////////////////////////////////////////
    // Two stage pipeline
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            micro_cnt <= '0;
            nano_cnt  <= '0;
            st0_phase <= '0;
            st1_phase <= '0;
        end else begin
            micro_cnt <= micro_cnt + 1'b1;
            if (update) begin
                nano_cnt <= nano_cnt + 1'b1;
            end
            if (update || async_update_en) begin
                st0_phase <= phase;
            end
            st1_phase <= st0_phase + (microstep_en ? micro_scaled : '0)
                                   + (nanostep_en ? nano_rev : '0);
        end
    end

    // One pulse at the last count of every PWM period.
    assign update  = (micro_cnt == {MICROSTEP_WIDTH{1'b1}});
    assign out_val = st1_phase[PHASE_WIDTH-1:Q_WIDTH];

endmodule

// File: verilog/coil_drive.sv
// Full-step coil driver of the stepper drive.
// Registers the H-bridge pattern for the current step position.
`timescale 1ns/10ps

module coil_drive #(
    parameter int OUTPUT_WIDTH = 16
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    oe,
    input  logic [OUTPUT_WIDTH-1:0] step_pos,
    output stepper_pkg::coil_t      coil
);

    logic [1:0]         step_phase;
    stepper_pkg::coil_t coil_next;

    // Four full steps make one electrical cycle.
    assign step_phase = step_pos[1:0];

    always_comb begin
        if (oe) begin
            coil_next = stepper_pkg::COIL_PATTERN[step_phase];
        end else begin
            // All four bridge inputs off lets the motor coast.
            coil_next = '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            coil <= '0;
        end else begin
            coil <= coil_next;
        end
    end

endmodule

// File: verilog/stepper_top.sv
// Top level of the single-axis stepper drive controller.
// APB registers, phase accumulator, microstep PWM and coil driver.
`timescale 1ns/10ps

module stepper_top #(
    parameter int PHASE_WIDTH     = 32,
    parameter int Q_WIDTH         = 16,
    parameter int MICROSTEP_WIDTH = 12
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  stepper_pkg::apb_addr_t paddr,
    input  stepper_pkg::apb_data_t pwdata,
    output stepper_pkg::apb_data_t prdata,
    output logic                   pready,
    output logic                   pslverr,
    output stepper_pkg::coil_t     coil,
    output logic                   period_tick
);

    localparam int OUTPUT_WIDTH = PHASE_WIDTH - Q_WIDTH;

    logic                    run;
    logic                    micro_en;
    logic                    nano_en;
    logic                    async_en;
    logic                    oe;
    logic [PHASE_WIDTH-1:0]  speed;
    logic                    phase_load_valid;
    logic [PHASE_WIDTH-1:0]  phase_load_value;
    logic [PHASE_WIDTH-1:0]  phase;
    logic [OUTPUT_WIDTH-1:0] step_pos;

    stepper_regs #(
        .PHASE_WIDTH (PHASE_WIDTH)
    ) i_stepper_regs (
        .clk              (clk),
        .reset            (reset),
        .psel             (psel),
        .penable          (penable),
        .pwrite           (pwrite),
        .paddr            (paddr),
        .pwdata           (pwdata),
        .prdata           (prdata),
        .pready           (pready),
        .pslverr          (pslverr),
        .phase            (phase),
        .coil             (coil),
        .run              (run),
        .micro_en         (micro_en),
        .nano_en          (nano_en),
        .async_en         (async_en),
        .oe               (oe),
        .speed            (speed),
        .phase_load_valid (phase_load_valid),
        .phase_load_value (phase_load_value)
    );

    phase_generator #(
        .PHASE_WIDTH (PHASE_WIDTH)
    ) i_phase_generator (
        .clk              (clk),
        .reset            (reset),
        .run              (run),
        .speed            (speed),
        .update           (period_tick),
        .phase_load_valid (phase_load_valid),
        .phase_load_value (phase_load_value),
        .phase            (phase)
    );

    // The PWM period pulse also paces the phase accumulator.
    microstep_pwm_control #(
        .PHASE_WIDTH     (PHASE_WIDTH),
        .Q_WIDTH         (Q_WIDTH),
        .MICROSTEP_WIDTH (MICROSTEP_WIDTH),
        .OUTPUT_WIDTH    (OUTPUT_WIDTH)
    ) i_microstep_pwm_control (
        .clk             (clk),
        .reset           (reset),
        .microstep_en    (micro_en),
        .nanostep_en     (nano_en),
        .async_update_en (async_en),
        .phase           (phase),
        .update          (period_tick),
        .out_val         (step_pos)
    );

    coil_drive #(
        .OUTPUT_WIDTH (OUTPUT_WIDTH)
    ) i_coil_drive (
        .clk      (clk),
        .reset    (reset),
        .oe       (oe),
        .step_pos (step_pos),
        .coil     (coil)
    );

endmodule

// File: tests/stepper_checker.sv
// Bound assertions for the stepper drive top level.
// Checks APB response behavior and coil output legality.
`timescale 1ns/10ps

module stepper_checker (
    input logic                   clk,
    input logic                   reset,
    input logic                   psel,
    input logic                   penable,
    input stepper_pkg::apb_addr_t paddr,
    input logic                   pready,
    input logic                   pslverr,
    input stepper_pkg::coil_t     coil
);

    logic access_valid;
    logic coil_legal;

    assign access_valid = psel && penable && (paddr <= stepper_pkg::STATUS_ADDR);

    // Coast (all off) or one of the four full-step patterns.
    assign coil_legal = (coil == 4'b0000) ||
                        (coil == stepper_pkg::COIL_PATTERN[0]) ||
                        (coil == stepper_pkg::COIL_PATTERN[1]) ||
                        (coil == stepper_pkg::COIL_PATTERN[2]) ||
                        (coil == stepper_pkg::COIL_PATTERN[3]);

    apb_valid_access: assert property (@(posedge clk) disable iff (reset)
        access_valid |-> (pready && !pslverr))
        else $error("APB access to a mapped address was not ready or flagged an error");

    apb_error_in_access: assert property (@(posedge clk) disable iff (reset)
        pslverr |-> (psel && penable))
        else $error("pslverr raised outside an APB access phase");

    coil_pattern_legal: assert property (@(posedge clk) disable iff (reset) coil_legal)
        else $error("Coil output is not a legal full-step pattern");

endmodule

bind stepper_top stepper_checker i_stepper_checker (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .paddr   (paddr),
    .pready  (pready),
    .pslverr (pslverr),
    .coil    (coil)
);

// File: tests/stepper_tb.sv
// Testbench for the stepper drive controller.
// Runs a stimulus table over APB and checks coil, STATUS and phase results.
`timescale 1ns/10ps

module stepper_tb;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 3;
    localparam int MICROSTEP_WIDTH = 4;
    localparam int PERIOD_CYCLES   = 1 << MICROSTEP_WIDTH;
    localparam int FRAC_ONE        = 256;
    localparam int MICRO_LSB       = FRAC_ONE / PERIOD_CYCLES;
    localparam int PIPE_CYCLES     = 3;
    localparam int SPEED_TICKS     = 4;
    localparam int READY_LIMIT     = 16;
    localparam int NUM_ROWS        = 13;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 200;

    localparam logic [1:0] KIND_STATIC = 2'd0;
    localparam logic [1:0] KIND_MICRO  = 2'd1;
    localparam logic [1:0] KIND_SPEED  = 2'd2;

    localparam logic [7:0] RUN_BIT   = 8'h01;
    localparam logic [7:0] MICRO_BIT = 8'h02;
    localparam logic [7:0] OE_BIT    = 8'h10;

    // Full-step sequence A+, A-, B+, B- for step positions 0 to 3.
    localparam logic [3:0] COIL_REF [4] = '{4'b1010, 4'b0110, 4'b0101, 4'b1001};

    typedef struct packed {
        logic [1:0]  kind;
        logic [7:0]  ctrl;
        logic [15:0] speed;
        logic [15:0] phase;
        logic [15:0] expected;
    } row_t;

    logic                   clk;
    logic                   reset;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    stepper_pkg::apb_addr_t paddr;
    stepper_pkg::apb_data_t pwdata;
    stepper_pkg::apb_data_t prdata;
    logic                   pready;
    logic                   pslverr;
    stepper_pkg::coil_t     coil;
    logic                   period_tick;

    row_t rows [NUM_ROWS];

    stepper_top #(
        .PHASE_WIDTH     (16),
        .Q_WIDTH         (8),
        .MICROSTEP_WIDTH (MICROSTEP_WIDTH)
    ) i_stepper_top (
        .clk         (clk),
        .reset       (reset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .coil        (coil),
        .period_tick (period_tick)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("Watchdog timeout: the tests did not finish in the allowed time.");
    end

    //////////////////////////////////////////////////////////////////////
    // Failure reporting and checks
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped after the first failure.");
    endtask

    task automatic check(input string what, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("** Error at %0t ns: %s is 0x%0h, expected 0x%0h",
                                $time, what, actual, expected));
        end
    endtask

    // Number of micro counter values whose scaled share carries the
    // fraction over into the next integer step.
    function automatic int micro_share(input logic [7:0] frac);
        int count;
        count = 0;
        for (int m = 0; m < PERIOD_CYCLES; m++) begin
            if (int'(frac) + m * MICRO_LSB >= FRAC_ONE) begin
                count++;
            end
        end
        return count;
    endfunction

    function automatic row_t make_row(input logic [1:0] kind, input logic [7:0] ctrl,
                                      input logic [15:0] speed, input logic [15:0] phase,
                                      input logic [15:0] expected);
        row_t row;
        row.kind     = kind;
        row.ctrl     = ctrl;
        row.speed    = speed;
        row.phase    = phase;
        row.expected = expected;
        return row;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Bus and timing tasks
    //////////////////////////////////////////////////////////////////////

    task automatic apply_reset();
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic wait_ready();
        int waits;
        waits = 0;
        while (!pready) begin
            @(negedge clk);
            waits++;
            if (waits > READY_LIMIT) begin
                abort_run("APB slave never raised pready in the access phase.");
            end
        end
    endtask

    task automatic apb_write(input stepper_pkg::apb_addr_t addr,
                             input stepper_pkg::apb_data_t data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        wait_ready();
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Response is sampled in the middle of the access phase.
    task automatic apb_read(input stepper_pkg::apb_addr_t addr,
                            output stepper_pkg::apb_data_t data, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        wait_ready();
        data = prdata;
        err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Counts ticks from the current falling edge on.
    task automatic count_ticks(input int n, output int seen);
        int cycles;
        seen   = 0;
        cycles = 0;
        if (period_tick) begin
            seen++;
        end
        while (seen < n) begin
            @(negedge clk);
            cycles++;
            if (period_tick) begin
                seen++;
            end else if (cycles > (n + 1) * PERIOD_CYCLES) begin
                abort_run("Timeout: period_tick stopped pulsing.");
            end
        end
    endtask

    // Two PWM periods, then the sample, stage and coil registers.
    task automatic settle();
        int seen;
        @(negedge clk);
        count_ticks(2, seen);
        repeat (PIPE_CYCLES) @(negedge clk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Table rows
    //////////////////////////////////////////////////////////////////////

    task automatic apply_row(input row_t row);
        stepper_pkg::apb_data_t data;
        logic                   err;
        int                     seen;
        int                     hits;
        logic [1:0]             next_idx;
        logic [15:0]            predicted;
        apb_write(stepper_pkg::CTRL_ADDR, 32'h0);
        apb_write(stepper_pkg::SPEED_ADDR, 32'(row.speed));
        apb_write(stepper_pkg::PHASE_ADDR, 32'(row.phase));
        apb_write(stepper_pkg::CTRL_ADDR, 32'(row.ctrl));
        next_idx = row.phase[9:8] + 2'd1;
        case (row.kind)
            KIND_STATIC: begin
                settle();
                check("coil", 32'(coil), 32'(row.expected[3:0]));
                apb_read(stepper_pkg::STATUS_ADDR, data, err);
                check("STATUS", data, 32'(row.expected[3:0]));
            end
            KIND_MICRO: begin
                settle();
                hits = 0;
                repeat (PERIOD_CYCLES) begin
                    if (coil == COIL_REF[next_idx]) begin
                        hits++;
                    end else begin
                        check("coil on step n", 32'(coil), 32'(COIL_REF[row.phase[9:8]]));
                    end
                    @(negedge clk);
                end
                check("cycles on step n+1", 32'(hits), 32'(row.expected));
            end
            default: begin
                count_ticks(SPEED_TICKS, seen);
                apb_write(stepper_pkg::CTRL_ADDR, 32'(OE_BIT));
                apb_read(stepper_pkg::PHASE_ADDR, data, err);
                predicted = row.phase + seen[15:0] * row.speed;
                check("phase after counted ticks", data, 32'(predicted));
                check("phase against table", data, 32'(row.expected));
            end
        endcase
    endtask

    initial begin
        stepper_pkg::apb_data_t data;
        logic                   err;
        logic [31:0]            rnd;
        void'($urandom(32'h1cec873a));
        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;

        // Static rows expect a coil pattern, micro rows a cycle count,
        // speed rows the final phase.
        rows[0]  = make_row(KIND_STATIC, OE_BIT, 16'h0000, 16'h0000, 16'b1010);
        rows[1]  = make_row(KIND_STATIC, OE_BIT, 16'h0000, 16'h01C0, 16'b0110);
        rows[2]  = make_row(KIND_STATIC, OE_BIT, 16'h0000, 16'h0280, 16'b0101);
        rows[3]  = make_row(KIND_STATIC, OE_BIT, 16'h0000, 16'h0700, 16'b1001);
        rnd = $urandom;
        rows[4]  = make_row(KIND_STATIC, OE_BIT, 16'h0000, rnd[15:0], 16'(COIL_REF[rnd[9:8]]));
        rnd = $urandom;
        rows[5]  = make_row(KIND_STATIC, OE_BIT, 16'h0000, rnd[15:0], 16'(COIL_REF[rnd[9:8]]));
        rows[6]  = make_row(KIND_MICRO, OE_BIT | MICRO_BIT, 16'h0000, 16'h0540, 16'd4);
        rows[7]  = make_row(KIND_MICRO, OE_BIT | MICRO_BIT, 16'h0000, 16'h02A0, 16'd10);
        rows[8]  = make_row(KIND_MICRO, OE_BIT | MICRO_BIT, 16'h0000, 16'h0300, 16'd0);
        rows[9]  = make_row(KIND_MICRO, OE_BIT | MICRO_BIT, 16'h0000, 16'h03F0, 16'd15);
        rnd = $urandom;
        rows[10] = make_row(KIND_MICRO, OE_BIT | MICRO_BIT, 16'h0000, rnd[15:0],
                            16'(micro_share(rnd[7:0])));
        rows[11] = make_row(KIND_SPEED, OE_BIT | RUN_BIT, 16'h0150, 16'h1234, 16'h1774);
        rows[12] = make_row(KIND_SPEED, OE_BIT | RUN_BIT, 16'hFF70, 16'h0100, 16'hFEC0);

        apply_reset();
        check("coil after reset", 32'(coil), 32'h0);
        apb_read(stepper_pkg::CTRL_ADDR, data, err);
        check("CTRL after reset", data, 32'h0);

        // Register readback, then an access above the register map.
        apb_write(stepper_pkg::CTRL_ADDR, 32'h0000_001E);
        apb_read(stepper_pkg::CTRL_ADDR, data, err);
        check("CTRL readback", data, 32'h0000_001E);
        check("pslverr on CTRL", 32'(err), 32'h0);
        apb_write(stepper_pkg::SPEED_ADDR, 32'h0000_A5C3);
        apb_read(stepper_pkg::SPEED_ADDR, data, err);
        check("SPEED readback", data, 32'h0000_A5C3);
        apb_write(stepper_pkg::PHASE_ADDR, 32'h0000_3C96);
        apb_read(stepper_pkg::PHASE_ADDR, data, err);
        check("PHASE readback", data, 32'h0000_3C96);
        apb_read(4'hE, data, err);
        check("pslverr above STATUS", 32'(err), 32'h1);

        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(rows[i]);
        end

        // Output enable, then a reset in the middle of a run.
        // The phase still holds the result of the last speed row.
        apb_write(stepper_pkg::CTRL_ADDR, 32'(OE_BIT));
        settle();
        apb_read(stepper_pkg::PHASE_ADDR, data, err);
        check("PHASE with oe set", data, 32'(rows[NUM_ROWS-1].expected));
        check("coil with oe set", 32'(coil),
              32'(COIL_REF[rows[NUM_ROWS-1].expected[9:8]]));
        apb_write(stepper_pkg::CTRL_ADDR, 32'h0);
        @(negedge clk);
        check("coil after oe cleared", 32'(coil), 32'h0);
        apb_write(stepper_pkg::CTRL_ADDR, 32'(OE_BIT | RUN_BIT));
        settle();
        apply_reset();
        check("coil after second reset", 32'(coil), 32'h0);
        apb_read(stepper_pkg::CTRL_ADDR, data, err);
        check("CTRL after second reset", data, 32'h0);
        apb_read(stepper_pkg::PHASE_ADDR, data, err);
        check("PHASE after second reset", data, 32'h0);

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: list.f
verilog/stepper_pkg.sv
verilog/stepper_regs.sv
verilog/phase_generator.sv
verilog/microstep_pwm_control.sv
verilog/coil_drive.sv
verilog/stepper_top.sv
tests/stepper_checker.sv
tests/stepper_tb.sv

// File: Makefile
TOP = stepper_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/10ps -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f list.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "NO ERRORS" $(LOG); then \
		echo "Simulation did not complete"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
